// ==== bench/hierarchy_trace.txt ====
# Per core, core 0 then core 1, all hex: active op addr wdata expected_rdata
# op 0 is a read, op 1 is a write; expected_rdata is checked on reads only
1 0 05 00000000 00000000 1 0 20 00000000 00000000
1 0 08 00000000 00000000 0 0 00 00000000 00000000
1 1 09 11112222 00000000 0 0 00 00000000 00000000
1 0 09 00000000 11112222 0 0 00 00000000 00000000
1 0 10 00000000 00000000 0 0 00 00000000 00000000
0 0 00 00000000 00000000 1 1 10 a5a5a5a5 00000000
1 0 10 00000000 a5a5a5a5 0 0 00 00000000 00000000
1 1 14 01020304 00000000 1 1 18 0a0b0c0d 00000000
1 0 18 00000000 0a0b0c0d 1 0 14 00000000 01020304
0 0 00 00000000 00000000 1 1 2c cafe0001 00000000
0 0 00 00000000 00000000 1 1 2e cafe0003 00000000
0 0 00 00000000 00000000 1 0 2c 00000000 cafe0001
0 0 00 00000000 00000000 1 0 2e 00000000 cafe0003
1 1 33 deadbeef 00000000 0 0 00 00000000 00000000
1 0 33 00000000 deadbeef 0 0 00 00000000 00000000
1 0 10 00000000 a5a5a5a5 0 0 00 00000000 00000000
1 0 2c 00000000 cafe0001 1 0 33 00000000 deadbeef
1 1 15 55aa55aa 00000000 0 0 00 00000000 00000000
0 0 00 00000000 00000000 1 0 15 00000000 55aa55aa

// ==== sim.f ====
design/cache_geometry_pkg.sv
design/coherence_pkg.sv
design/l1_cache.sv
design/coherence_controller.sv
design/line_memory.sv
design/cache_hierarchy.sv
bench/cache_hierarchy_checker.sv
bench/tb_cache_hierarchy.sv

// ==== Bender.yml ====
package:
  name: cache_hierarchy

sources:
  - design/cache_geometry_pkg.sv
  - design/coherence_pkg.sv
  - design/l1_cache.sv
  - design/coherence_controller.sv
  - design/line_memory.sv
  - design/cache_hierarchy.sv
  - target: test
    files:
      - bench/cache_hierarchy_checker.sv
      - bench/tb_cache_hierarchy.sv

// ==== bench/tb_cache_hierarchy.sv ====
`default_nettype none

module tb_cache_hierarchy;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES    = 10;
    localparam int CYCLES_PER_STEP = 60;
    localparam int MAX_STEPS       = 64;

    logic                      clock;
    logic                      reset;
    logic                      core_req_0;
    coherence_pkg::core_op_e   core_op_0;
    cache_geometry_pkg::addr_t core_addr_0;
    cache_geometry_pkg::word_t core_wdata_0;
    logic                      core_ack_0;
    cache_geometry_pkg::word_t core_rdata_0;
    logic                      core_req_1;
    coherence_pkg::core_op_e   core_op_1;
    cache_geometry_pkg::addr_t core_addr_1;
    cache_geometry_pkg::word_t core_wdata_1;
    logic                      core_ack_1;
    cache_geometry_pkg::word_t core_rdata_1;

    // Trace steps, second index is the core
    logic                      trace_active [MAX_STEPS][2];
    coherence_pkg::core_op_e   trace_op     [MAX_STEPS][2];
    cache_geometry_pkg::addr_t trace_addr   [MAX_STEPS][2];
    cache_geometry_pkg::word_t trace_wdata  [MAX_STEPS][2];
    cache_geometry_pkg::word_t trace_rdata  [MAX_STEPS][2];
    int                        num_steps   = 0;
    int                        cycle_limit = 0;
    int                        cycle_count = 0;

    // Port names match the DUT one to one
    cache_hierarchy dut_i (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    // Step file, comment lines start with #
    task automatic load_trace();
        int          fd;
        int          fields;
        string       text;
        logic [31:0] col [10];
        fd = $fopen("bench/hierarchy_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file bench/hierarchy_trace.txt");
            $display("Simulation FAILED");
            $fatal(1, "Trace file missing");
        end else begin
            while ($fgets(text, fd) != 0 && num_steps < MAX_STEPS) begin
                if (text.len() > 1 && text.getc(0) != "#") begin
                    fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h",
                                     col[0], col[1], col[2], col[3], col[4],
                                     col[5], col[6], col[7], col[8], col[9]);
                    if (fields == 10) begin
                        for (int c = 0; c < 2; c++) begin
                            trace_active[num_steps][c] = col[c*5][0];
                            trace_op[num_steps][c]     = coherence_pkg::core_op_e'(col[c*5+1][0]);
                            trace_addr[num_steps][c]   = cache_geometry_pkg::addr_t'(col[c*5+2]);
                            trace_wdata[num_steps][c]  = col[c*5+3];
                            trace_rdata[num_steps][c]  = col[c*5+4];
                        end
                        num_steps++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic ack_of(input int core);
        return (core == 0) ? core_ack_0 : core_ack_1;
    endfunction

    function automatic cache_geometry_pkg::word_t rdata_of(input int core);
        return (core == 0) ? core_rdata_0 : core_rdata_1;
    endfunction

    // Op as the L1 decoded it, a write leaves as a bus write and a read as a fill
    function automatic coherence_pkg::core_op_e op_of(input int core);
        coherence_pkg::bus_op_e decoded;
        decoded = (core == 0) ? dut_i.l1_0.bus_op : dut_i.l1_1.bus_op;
        return (decoded == coherence_pkg::BUS_WRITE) ? coherence_pkg::OP_WRITE
                                                     : coherence_pkg::OP_READ;
    endfunction

    task automatic compare_word(input int core, input cache_geometry_pkg::word_t actual,
                                input cache_geometry_pkg::word_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: core %0d read %h, expected %h",
                     $time, core, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Read data check failed");
        end
    endtask

    task automatic compare_op_done(input int core, input coherence_pkg::core_op_e actual,
                                   input coherence_pkg::core_op_e expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: core %0d completed %s, issued %s",
                     $time, core, actual.name(), expected.name());
            $display("Simulation FAILED");
            $fatal(1, "Completed op check failed");
        end
    endtask

    // Raise req with fields, all on one edge
    task automatic start_request(input int core, input int step);
        if (core == 0) begin
            core_req_0   <= 1'b1;
            core_op_0    <= trace_op[step][0];
            core_addr_0  <= trace_addr[step][0];
            core_wdata_0 <= trace_wdata[step][0];
        end else begin
            core_req_1   <= 1'b1;
            core_op_1    <= trace_op[step][1];
            core_addr_1  <= trace_addr[step][1];
            core_wdata_1 <= trace_wdata[step][1];
        end
    endtask

    task automatic drop_request(input int core);
        if (core == 0) begin
            core_req_0 <= 1'b0;
        end else begin
            core_req_1 <= 1'b0;
        end
    endtask

    // One full four phase handshake for one core
    task automatic run_core(input int core, input int step);
        if (trace_active[step][core]) begin
            @(posedge clock);
            start_request(core, step);
            do begin
                @(posedge clock);
            end while (!ack_of(core));
            compare_op_done(core, op_of(core), trace_op[step][core]);
            // Read data only means something on a read
            if (trace_op[step][core] == coherence_pkg::OP_READ) begin
                compare_word(core, rdata_of(core), trace_rdata[step][core]);
            end
            drop_request(core);
            do begin
                @(posedge clock);
            end while (ack_of(core));
        end
    endtask

    // Run limit grows with the trace length
    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the trace did not finish within %0d cycles", cycle_limit);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped by timeout");
    end

    initial begin
        int unsigned gap;
        void'($urandom(43));
        reset        = 1'b1;
        core_req_0   = 1'b0;
        core_op_0    = coherence_pkg::OP_READ;
        core_addr_0  = '0;
        core_wdata_0 = '0;
        core_req_1   = 1'b0;
        core_op_1    = coherence_pkg::OP_READ;
        core_addr_1  = '0;
        core_wdata_1 = '0;
        load_trace();
        if (num_steps == 0) begin
            $display("The trace file holds no steps");
            $display("Simulation FAILED");
            $fatal(1, "Empty trace");
        end
        cycle_limit = RESET_CYCLES + CYCLES_PER_STEP * num_steps;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        for (int s = 0; s < num_steps; s++) begin
            // Idle gap between steps
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge clock);
            fork
                run_core(0, s);
                run_core(1, s);
            join
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cache_hierarchy_checker.sv ====
`default_nettype none

module cache_hierarchy_checker (
    input logic clock,
    input logic reset,
    input logic core_req_0,
    input logic core_ack_0,
    input logic core_req_1,
    input logic core_ack_1,
    input logic bus_req_0,
    input logic bus_req_1,
    input logic bus_ack_0,
    input logic bus_ack_1,
    input logic inv_valid_0,
    input logic inv_valid_1
);

    timeunit 1ns;
    timeprecision 1ps;

    // Ack only answers a live request
    assert property (@(posedge clock) disable iff (reset) $rose(core_ack_0) |-> core_req_0)
        else $error("core_ack_0 rose while core_req_0 was low");
    assert property (@(posedge clock) disable iff (reset) $rose(core_ack_1) |-> core_req_1)
        else $error("core_ack_1 rose while core_req_1 was low");

    // Grant goes only to a cache still holding its bus request
    assert property (@(posedge clock) disable iff (reset) $rose(bus_ack_0) |-> bus_req_0)
        else $error("bus_ack_0 rose while bus_req_0 was low");
    assert property (@(posedge clock) disable iff (reset) $rose(bus_ack_1) |-> bus_req_1)
        else $error("bus_ack_1 rose while bus_req_1 was low");

    // Invalidate is a one cycle pulse
    assert property (@(posedge clock) disable iff (reset) inv_valid_0 |=> !inv_valid_0)
        else $error("inv_valid_0 held longer than one cycle");
    assert property (@(posedge clock) disable iff (reset) inv_valid_1 |=> !inv_valid_1)
        else $error("inv_valid_1 held longer than one cycle");

endmodule

bind cache_hierarchy cache_hierarchy_checker checker_i (.*);

`default_nettype wire

// ==== design/cache_hierarchy.sv ====
`default_nettype none

module cache_hierarchy (
    input  logic                      clock,
    input  logic                      reset,
    // Core 0
    input  logic                      core_req_0,
    input  coherence_pkg::core_op_e   core_op_0,
    input  cache_geometry_pkg::addr_t core_addr_0,
    input  cache_geometry_pkg::word_t core_wdata_0,
    output logic                      core_ack_0,
    output cache_geometry_pkg::word_t core_rdata_0,
    // Core 1
    input  logic                      core_req_1,
    input  coherence_pkg::core_op_e   core_op_1,
    input  cache_geometry_pkg::addr_t core_addr_1,
    input  cache_geometry_pkg::word_t core_wdata_1,
    output logic                      core_ack_1,
    output cache_geometry_pkg::word_t core_rdata_1
);

    // L1 to controller, per cache
    logic                           bus_req_0, bus_req_1;
    coherence_pkg::bus_op_e         bus_op_0, bus_op_1;
    cache_geometry_pkg::addr_t      bus_addr_0, bus_addr_1;
    cache_geometry_pkg::word_t      bus_wdata_0, bus_wdata_1;
    logic                           bus_ack_0, bus_ack_1;
    cache_geometry_pkg::line_t      bus_line_0, bus_line_1;
    logic                           inv_valid_0, inv_valid_1;
    cache_geometry_pkg::line_addr_t inv_line_0, inv_line_1;

    // Controller to memory
    logic                           mem_write;
    cache_geometry_pkg::line_addr_t mem_line_addr;
    cache_geometry_pkg::offset_t    mem_offset;
    cache_geometry_pkg::word_t      mem_wdata;
    cache_geometry_pkg::line_t      mem_rline;

    l1_cache l1_0 (
        .clock, .reset,
        .core_req(core_req_0), .core_op(core_op_0), .core_addr(core_addr_0),
        .core_wdata(core_wdata_0), .core_ack(core_ack_0), .core_rdata(core_rdata_0),
        .bus_req(bus_req_0), .bus_op(bus_op_0), .bus_addr(bus_addr_0),
        .bus_wdata(bus_wdata_0), .bus_ack(bus_ack_0), .bus_line(bus_line_0),
        .inv_valid(inv_valid_0), .inv_line(inv_line_0)
    );

    l1_cache l1_1 (
        .clock, .reset,
        .core_req(core_req_1), .core_op(core_op_1), .core_addr(core_addr_1),
        .core_wdata(core_wdata_1), .core_ack(core_ack_1), .core_rdata(core_rdata_1),
        .bus_req(bus_req_1), .bus_op(bus_op_1), .bus_addr(bus_addr_1),
        .bus_wdata(bus_wdata_1), .bus_ack(bus_ack_1), .bus_line(bus_line_1),
        .inv_valid(inv_valid_1), .inv_line(inv_line_1)
    );

    coherence_controller controller (
        .clock, .reset,
        .bus_req_0, .bus_op_0, .bus_addr_0, .bus_wdata_0,
        .bus_ack_0, .bus_line_0, .inv_valid_0, .inv_line_0,
        .bus_req_1, .bus_op_1, .bus_addr_1, .bus_wdata_1,
        .bus_ack_1, .bus_line_1, .inv_valid_1, .inv_line_1,
        .mem_write, .mem_line_addr, .mem_offset, .mem_wdata, .mem_rline
    );

    line_memory memory (
        .clock, .reset,
        .mem_write, .mem_line_addr, .mem_offset, .mem_wdata, .mem_rline
    );

endmodule

`default_nettype wire

// ==== design/line_memory.sv ====
`default_nettype none

module line_memory (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           mem_write,
    input  cache_geometry_pkg::line_addr_t mem_line_addr,
    input  cache_geometry_pkg::offset_t    mem_offset,
    input  cache_geometry_pkg::word_t      mem_wdata,
    output cache_geometry_pkg::line_t      mem_rline
);

    cache_geometry_pkg::line_t lines [cache_geometry_pkg::MEM_LINES];

    // Zero fill on reset, word writes otherwise
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < cache_geometry_pkg::MEM_LINES; i++) begin
                lines[i] <= '0;
            end
        end else if (mem_write) begin
            lines[mem_line_addr][mem_offset*cache_geometry_pkg::WORD_BITS +:
                                 cache_geometry_pkg::WORD_BITS] <= mem_wdata;
        end
    end

    // Registered whole line read, old data on a same cycle write
    always_ff @(posedge clock) begin
        mem_rline <= lines[mem_line_addr];
    end

endmodule

`default_nettype wire

// ==== design/coherence_controller.sv ====
`default_nettype none

module coherence_controller (
    input  logic                           clock,
    input  logic                           reset,
    // Cache 0 bus
    input  logic                           bus_req_0,
    input  coherence_pkg::bus_op_e         bus_op_0,
    input  cache_geometry_pkg::addr_t      bus_addr_0,
    input  cache_geometry_pkg::word_t      bus_wdata_0,
    output logic                           bus_ack_0,
    output cache_geometry_pkg::line_t      bus_line_0,
    output logic                           inv_valid_0,
    output cache_geometry_pkg::line_addr_t inv_line_0,
    // Cache 1 bus
    input  logic                           bus_req_1,
    input  coherence_pkg::bus_op_e         bus_op_1,
    input  cache_geometry_pkg::addr_t      bus_addr_1,
    input  cache_geometry_pkg::word_t      bus_wdata_1,
    output logic                           bus_ack_1,
    output cache_geometry_pkg::line_t      bus_line_1,
    output logic                           inv_valid_1,
    output cache_geometry_pkg::line_addr_t inv_line_1,
    // Memory port
    output logic                           mem_write,
    output cache_geometry_pkg::line_addr_t mem_line_addr,
    output cache_geometry_pkg::offset_t    mem_offset,
    output cache_geometry_pkg::word_t      mem_wdata,
    input  cache_geometry_pkg::line_t      mem_rline
);

    coherence_pkg::ctrl_state_e state;

    // Index of the cache that owns the bus
    logic [$clog2(cache_geometry_pkg::NUM_CORES)-1:0] grant;
    logic                                             ack_q;
    cache_geometry_pkg::line_t                        line_q;

    logic                      sel_req;
    coherence_pkg::bus_op_e    sel_op;
    cache_geometry_pkg::addr_t sel_addr;
    cache_geometry_pkg::word_t sel_wdata;
    logic                      write_ack;

    // Granted request mux
    always_comb begin
        if (grant == 1'b1) begin
            sel_req   = bus_req_1;
            sel_op    = bus_op_1;
            sel_addr  = bus_addr_1;
            sel_wdata = bus_wdata_1;
        end else begin
            sel_req   = bus_req_0;
            sel_op    = bus_op_0;
            sel_addr  = bus_addr_0;
            sel_wdata = bus_wdata_0;
        end
    end

    // Memory sees the address during ACCESS only for writes
    assign mem_write     = (state == coherence_pkg::CTRL_ACCESS) &&
                           (sel_op == coherence_pkg::BUS_WRITE);
    assign mem_line_addr = sel_addr[cache_geometry_pkg::ADDR_BITS-1:cache_geometry_pkg::OFFSET_BITS];
    assign mem_offset    = sel_addr[cache_geometry_pkg::OFFSET_BITS-1:0];
    assign mem_wdata     = sel_wdata;

    // Single cycle invalidate to the cache that did not write
    assign write_ack   = (state == coherence_pkg::CTRL_ACK) &&
                         (sel_op == coherence_pkg::BUS_WRITE);
    assign inv_valid_0 = write_ack && (grant == 1'b1);
    assign inv_valid_1 = write_ack && (grant == 1'b0);
    assign inv_line_0  = mem_line_addr;
    assign inv_line_1  = mem_line_addr;

    assign bus_ack_0  = ack_q && (grant == 1'b0);
    assign bus_ack_1  = ack_q && (grant == 1'b1);
    assign bus_line_0 = line_q;
    assign bus_line_1 = line_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= coherence_pkg::CTRL_IDLE;
            grant <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            case (state)
                coherence_pkg::CTRL_IDLE: begin
                    // Cache 0 wins a tie
                    if (bus_req_0) begin
                        grant <= 1'b0;
                        state <= coherence_pkg::CTRL_ACCESS;
                    end else if (bus_req_1) begin
                        grant <= 1'b1;
                        state <= coherence_pkg::CTRL_ACCESS;
                    end
                end
                coherence_pkg::CTRL_ACCESS: begin
                    state <= coherence_pkg::CTRL_ACK;
                end
                coherence_pkg::CTRL_ACK: begin
                    ack_q <= 1'b1;
                    state <= coherence_pkg::CTRL_RELEASE;
                end
                coherence_pkg::CTRL_RELEASE: begin
                    if (!sel_req) begin
                        ack_q <= 1'b0;
                        state <= coherence_pkg::CTRL_IDLE;
                    end
                end
                default: begin
                    state <= coherence_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

    // Memory line is valid during ACK, hold it for the requester
    always_ff @(posedge clock) begin
        if (state == coherence_pkg::CTRL_ACK) begin
            line_q <= mem_rline;
        end
    end

endmodule

`default_nettype wire

// ==== design/l1_cache.sv ====
`default_nettype none

module l1_cache (
    input  logic                           clock,
    input  logic                           reset,
    // Core handshake
    input  logic                           core_req,
    input  coherence_pkg::core_op_e        core_op,
    input  cache_geometry_pkg::addr_t      core_addr,
    input  cache_geometry_pkg::word_t      core_wdata,
    output logic                           core_ack,
    output cache_geometry_pkg::word_t      core_rdata,
    // Bus handshake towards the controller
    output logic                           bus_req,
    output coherence_pkg::bus_op_e         bus_op,
    output cache_geometry_pkg::addr_t      bus_addr,
    output cache_geometry_pkg::word_t      bus_wdata,
    input  logic                           bus_ack,
    input  cache_geometry_pkg::line_t      bus_line,
    // Invalidate pulse from the controller
    input  logic                           inv_valid,
    input  cache_geometry_pkg::line_addr_t inv_line
);

    coherence_pkg::l1_state_e state;

    // One entry per set, direct mapped
    logic [(1 << cache_geometry_pkg::INDEX_BITS)-1:0] valid;
    cache_geometry_pkg::tag_t  tags  [1 << cache_geometry_pkg::INDEX_BITS];
    cache_geometry_pkg::line_t lines [1 << cache_geometry_pkg::INDEX_BITS];

    cache_geometry_pkg::index_t  req_index;
    cache_geometry_pkg::tag_t    req_tag;
    cache_geometry_pkg::offset_t req_offset;
    cache_geometry_pkg::index_t  inv_index;
    cache_geometry_pkg::tag_t    inv_tag;
    cache_geometry_pkg::word_t   hit_word;
    cache_geometry_pkg::word_t   fill_word;
    logic                        hit;
    logic                        fill_now;
    logic                        inv_match;

    // Address fields of the held core request
    assign req_offset = core_addr[cache_geometry_pkg::OFFSET_BITS-1:0];
    assign req_index  = core_addr[cache_geometry_pkg::OFFSET_BITS +: cache_geometry_pkg::INDEX_BITS];
    assign req_tag    = core_addr[cache_geometry_pkg::ADDR_BITS-1 -: cache_geometry_pkg::TAG_BITS];

    // Invalidate carries a line address, no offset
    assign inv_index = inv_line[cache_geometry_pkg::INDEX_BITS-1:0];
    assign inv_tag   = inv_line[cache_geometry_pkg::LINE_ADDR_BITS-1 -: cache_geometry_pkg::TAG_BITS];

    assign hit = valid[req_index] && (tags[req_index] == req_tag);

    // Word selection from the stored line and from the incoming fill
    assign hit_word  = lines[req_index][req_offset*cache_geometry_pkg::WORD_BITS +:
                                        cache_geometry_pkg::WORD_BITS];
    assign fill_word = bus_line[req_offset*cache_geometry_pkg::WORD_BITS +:
                                cache_geometry_pkg::WORD_BITS];

    // Fill data arrives on the edge where ack is first seen
    assign fill_now = (state == coherence_pkg::L1_BUS) && bus_req && bus_ack &&
                      (bus_op == coherence_pkg::BUS_FILL);

    // Also catches a fill of the same line landing this cycle
    assign inv_match = inv_valid && ((tags[inv_index] == inv_tag) ||
                       (fill_now && (req_index == inv_index) && (req_tag == inv_tag)));

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= coherence_pkg::L1_IDLE;
            core_ack <= 1'b0;
            bus_req  <= 1'b0;
            valid    <= '0;
        end else begin
            case (state)
                coherence_pkg::L1_IDLE: begin
                    if (core_req) begin
                        state <= coherence_pkg::L1_LOOKUP;
                    end
                end
                coherence_pkg::L1_LOOKUP: begin
                    // Read hit answers locally, all else goes to the bus
                    if ((core_op == coherence_pkg::OP_READ) && hit) begin
                        core_ack <= 1'b1;
                        state    <= coherence_pkg::L1_ACK;
                    end else begin
                        bus_req <= 1'b1;
                        state   <= coherence_pkg::L1_BUS;
                    end
                end
                coherence_pkg::L1_BUS: begin
                    if (bus_req && bus_ack) begin
                        bus_req <= 1'b0;
                        if (fill_now) begin
                            valid[req_index] <= 1'b1;
                        end
                    end else if (!bus_req && !bus_ack) begin
                        // Bus handshake closed, answer the core
                        core_ack <= 1'b1;
                        state    <= coherence_pkg::L1_ACK;
                    end
                end
                coherence_pkg::L1_ACK: begin
                    if (!core_req) begin
                        core_ack <= 1'b0;
                        state    <= coherence_pkg::L1_IDLE;
                    end
                end
                default: begin
                    state <= coherence_pkg::L1_IDLE;
                end
            endcase
            // Last assignment wins over a same cycle fill
            if (inv_match) begin
                valid[inv_index] <= 1'b0;
            end
        end
    end

    // Arrays and bus payload
    always_ff @(posedge clock) begin
        case (state)
            coherence_pkg::L1_LOOKUP: begin
                if (core_op == coherence_pkg::OP_WRITE) begin
                    bus_op <= coherence_pkg::BUS_WRITE;
                end else begin
                    bus_op <= coherence_pkg::BUS_FILL;
                end
                bus_addr  <= core_addr;
                bus_wdata <= core_wdata;
                if (hit) begin
                    core_rdata <= hit_word;
                end
                // Write through, keep own copy current on a hit
                if ((core_op == coherence_pkg::OP_WRITE) && hit) begin
                    lines[req_index][req_offset*cache_geometry_pkg::WORD_BITS +:
                                     cache_geometry_pkg::WORD_BITS] <= core_wdata;
                end
            end
            coherence_pkg::L1_BUS: begin
                if (fill_now) begin
                    lines[req_index] <= bus_line;
                    tags[req_index]  <= req_tag;
                    core_rdata       <= fill_word;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/coherence_pkg.sv ====
`default_nettype none

package coherence_pkg;

    // Core side request kind
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } core_op_e;

    // L1 to controller request kind
    typedef enum logic {
        BUS_FILL,
        BUS_WRITE
    } bus_op_e;

    typedef enum logic [1:0] {
        L1_IDLE,
        L1_LOOKUP,
        L1_BUS,
        L1_ACK
    } l1_state_e;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ACCESS,
        CTRL_ACK,
        CTRL_RELEASE
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== design/cache_geometry_pkg.sv ====
`default_nettype none

package cache_geometry_pkg;

    // Word and line sizes
    localparam int unsigned WORD_BITS      = 32;
    localparam int unsigned OFFSET_BITS    = 2;
    localparam int unsigned WORDS_PER_LINE = 1 << OFFSET_BITS;
    localparam int unsigned LINE_BITS      = WORD_BITS * WORDS_PER_LINE;

    // Word address split as tag, index, offset
    localparam int unsigned INDEX_BITS     = 3;
    localparam int unsigned ADDR_BITS      = 6;
    localparam int unsigned TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int unsigned LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

    // Backing store depth and number of L1s
    localparam int unsigned MEM_LINES      = 1 << LINE_ADDR_BITS;
    localparam int unsigned NUM_CORES      = 2;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [LINE_BITS-1:0]      line_t;
    typedef logic [ADDR_BITS-1:0]      addr_t;
    // Address with the word offset stripped
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [INDEX_BITS-1:0]     index_t;
    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [OFFSET_BITS-1:0]    offset_t;

endpackage

`default_nettype wire
